// File: Bender.yml
package:
  name: pipe_cpu

sources:
  - include_dirs:
      - .
    files:
      - cpu_isa_pkg.sv
      - cpu_pipe_pkg.sv
      - fetch_unit.sv
      - decode_unit.sv
      - reg_file.sv
      - alu_exec.sv
      - mul_pipe.sv
      - hazard_control.sv
      - pipe_cpu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - pipe_cpu_sva.sv
      - tb_pipe_cpu.sv

// File: alu_exec.sv
`timescale 1ns/1ps

module alu_exec
   import cpu_isa_pkg::*;
   import cpu_pipe_pkg::*;
(
   input  logic     clk,
   input  logic     if_id_reset,
   input  logic     ex_valid,
   input  logic     ex_is_mul,
   input  reg_idx_t ex_dst,
   input  alu_op_t  ex_op,
   input  word_t    ex_opa,
   input  word_t    ex_opb,
   input  fwd_sel_t fwd_sel1,
   input  fwd_sel_t fwd_sel2,
   output logic     wb_alu_valid,
   output reg_idx_t wb_alu_dst,
   output word_t    wb_alu_result
);

   word_t opa;
   word_t opb;
   word_t result;

   always_comb begin
      opa = (fwd_sel1 == FWD_EXWB) ? wb_alu_result : ex_opa;
      opb = (fwd_sel2 == FWD_EXWB) ? wb_alu_result : ex_opb;
      case (ex_op)
         ALU_ADD: result = opa + opb;
         ALU_SUB: result = opa - opb;
         ALU_AND: result = opa & opb;
         ALU_OR:  result = opa | opb;
         ALU_SLT: result = word_t'($signed(opa) < $signed(opb));  // Signed compare
         default: result = opa + opb;
      endcase
   end

   always_ff @(posedge clk) begin
      if (if_id_reset) begin
         wb_alu_valid <= 1'b0;
      end else begin
         wb_alu_valid <= ex_valid & ~ex_is_mul;  // Multiplies go the long way
      end
   end

   always_ff @(posedge clk) begin
      wb_alu_dst    <= ex_dst;
      wb_alu_result <= result;
   end

endmodule

// File: cpu_isa_pkg.sv
`include "cpu_params.svh"

package cpu_isa_pkg;

   // Major opcodes, anything else decodes as a no-op
   typedef enum logic [5:0] {
      OP_RTYPE = 6'h00,
      OP_ADDI  = 6'h08
   } opcode_t;

   // R-type function codes
   typedef enum logic [5:0] {
      FN_MUL = 6'h18,
      FN_ADD = 6'h20,
      FN_SUB = 6'h22,
      FN_AND = 6'h24,
      FN_OR  = 6'h25,
      FN_SLT = 6'h2A
   } funct_t;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_SLT
   } alu_op_t;

   typedef struct packed {
      opcode_t                opcode;
      logic [`REG_ADDR_W-1:0] rs;
      logic [`REG_ADDR_W-1:0] rt;
      logic [`REG_ADDR_W-1:0] rd;
      logic [4:0]             shamt;  // Ignored
      funct_t                 funct;
   } r_instr_t;

   typedef struct packed {
      opcode_t                opcode;
      logic [`REG_ADDR_W-1:0] rs;
      logic [`REG_ADDR_W-1:0] rt;
      logic [15:0]            imm;
   } i_instr_t;

endpackage

// File: cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Datapath sizing
`define XLEN        32
`define REG_ADDR_W  5
`define NUM_REGS    32

// Multiply pipeline depth, the ALU path takes 2 cycles from decode to retire
`define MUL_STAGES  5

// Program counter
`define RESET_PC    32'h0000_0000
`define PC_STEP     32'd4

`endif

// File: cpu_pipe_pkg.sv
`include "cpu_params.svh"

package cpu_pipe_pkg;

   // Register index, index 0 is hardwired to zero
   typedef logic [`REG_ADDR_W-1:0] reg_idx_t;

   // One data word
   typedef logic [`XLEN-1:0] word_t;

   // Operand source in execute
   typedef enum logic {
      FWD_REG  = 1'b0,  // Value read in decode
      FWD_EXWB = 1'b1   // Result held at the execute/writeback boundary
   } fwd_sel_t;

endpackage

// File: decode_unit.sv
`timescale 1ns/1ps

module decode_unit
   import cpu_isa_pkg::*;
   import cpu_pipe_pkg::*;
(
   input  logic     clk,
   input  logic     if_id_reset,
   input  logic     stall,
   input  word_t    if_instr,
   input  word_t    rd_data1,
   input  word_t    rd_data2,
   output reg_idx_t src1,
   output reg_idx_t src2,
   output logic     src2_used,
   output reg_idx_t id_dst,
   output logic     id_is_alu,
   output logic     id_is_mul,
   output logic     ex_valid,
   output logic     ex_is_mul,
   output reg_idx_t ex_dst,
   output alu_op_t  ex_op,
   output word_t    ex_opa,
   output word_t    ex_opb,
   output reg_idx_t ex_src1,
   output reg_idx_t ex_src2
);

   r_instr_t r_fmt;
   i_instr_t i_fmt;
   alu_op_t  id_op;
   word_t    imm_ext;

   assign r_fmt   = r_instr_t'(if_instr);
   assign i_fmt   = i_instr_t'(if_instr);
   assign src1    = r_fmt.rs;
   assign src2    = r_fmt.rt;
   assign imm_ext = word_t'($signed(i_fmt.imm));  // Sign extended

   always_comb begin
      id_is_alu = 1'b0;
      id_is_mul = 1'b0;
      src2_used = 1'b0;
      id_dst    = '0;
      id_op     = ALU_ADD;
      case (r_fmt.opcode)
         OP_RTYPE: begin
            id_dst    = r_fmt.rd;
            src2_used = 1'b1;
            id_is_alu = 1'b1;
            case (r_fmt.funct)
               FN_ADD:  id_op = ALU_ADD;
               FN_SUB:  id_op = ALU_SUB;
               FN_AND:  id_op = ALU_AND;
               FN_OR:   id_op = ALU_OR;
               FN_SLT:  id_op = ALU_SLT;
               FN_MUL: begin
                  id_is_alu = 1'b0;
                  id_is_mul = 1'b1;
               end
               default: id_is_alu = 1'b0;
            endcase
         end
         OP_ADDI: begin
            id_dst    = i_fmt.rt;
            id_is_alu = 1'b1;
         end
         default: ;
      endcase
      // Unknown encoding, no destination and no sources
      if (!id_is_alu && !id_is_mul) begin
         id_dst    = '0;
         src2_used = 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (if_id_reset) begin
         ex_valid  <= 1'b0;
         ex_is_mul <= 1'b0;
      end else begin
         ex_valid  <= (id_is_alu | id_is_mul) & ~stall;  // Bubble on stall
         ex_is_mul <= id_is_mul & ~stall;
      end
   end

   always_ff @(posedge clk) begin
      ex_dst  <= id_dst;
      ex_op   <= id_op;
      ex_opa  <= rd_data1;
      ex_opb  <= src2_used ? rd_data2 : imm_ext;
      ex_src1 <= src1;
      ex_src2 <= src2_used ? src2 : '0;  // Immediate is never forwarded
   end

endmodule

// File: fetch_unit.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module fetch_unit
   import cpu_pipe_pkg::*;
(
   input  logic  clk,
   input  logic  if_id_reset,
   input  logic  stall,
   input  word_t imem_data,
   output word_t imem_addr,
   output word_t if_instr
);

   word_t pc;

   assign imem_addr = pc;  // ROM answers in the same cycle

   always_ff @(posedge clk) begin
      if (if_id_reset) begin
         pc       <= `RESET_PC;
         if_instr <= '0;  // All-zero word is a no-op
      end else if (!stall) begin
         pc       <= pc + `PC_STEP;
         if_instr <= imem_data;
      end
   end

endmodule

// File: hazard_control.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module hazard_control
   import cpu_pipe_pkg::*;
(
   input  reg_idx_t                   src1,
   input  reg_idx_t                   src2,
   input  logic                       src2_used,
   input  reg_idx_t                   id_dst,
   input  logic                       id_is_alu,
   input  logic                       id_is_mul,
   input  logic                       ex_valid,
   input  logic                       ex_is_mul,
   input  reg_idx_t                   ex_dst,
   input  reg_idx_t                   ex_src1,
   input  reg_idx_t                   ex_src2,
   input  logic     [`MUL_STAGES-1:0] stage_valid,
   input  reg_idx_t [`MUL_STAGES-1:0] stage_dst,
   input  logic                       wb_alu_valid,
   input  reg_idx_t                   wb_alu_dst,
   output logic                       stall,
   output fwd_sel_t                   fwd_sel1,
   output fwd_sel_t                   fwd_sel2
);

   // Stage whose multiply retires together with an ALU op now in decode
   localparam int SLOT_STAGE = `MUL_STAGES - 3;

   logic                     id_writes;
   logic     [`MUL_STAGES:0] busy_valid;
   reg_idx_t [`MUL_STAGES:0] busy_dst;
   logic                     mul_hit;
   logic                     mul_src_dep;
   logic                     slot_busy;

   assign id_writes  = id_is_alu | id_is_mul;  // Also means src1 is read
   assign busy_valid = {stage_valid, ex_valid & ex_is_mul};
   assign busy_dst   = {stage_dst, ex_dst};

   // Scoreboard over every multiply not yet retired
   always_comb begin
      mul_hit = 1'b0;
      for (int k = 0; k <= `MUL_STAGES; k++) begin
         if (busy_valid[k] && busy_dst[k] != '0) begin
            if ((id_writes && (busy_dst[k] == src1 || busy_dst[k] == id_dst)) ||
                (src2_used && busy_dst[k] == src2)) begin
               mul_hit = 1'b1;
            end
         end
      end
   end

   // Multiply operands are not forwarded, wait for the ALU result to retire
   assign mul_src_dep = id_is_mul && ex_valid && !ex_is_mul && ex_dst != '0 &&
                        (ex_dst == src1 || (src2_used && ex_dst == src2));

   assign slot_busy = id_is_alu && stage_valid[SLOT_STAGE];
   assign stall     = mul_hit | mul_src_dep | slot_busy;

   assign fwd_sel1 = (wb_alu_valid && wb_alu_dst != '0 && wb_alu_dst == ex_src1) ?
                     FWD_EXWB : FWD_REG;
   assign fwd_sel2 = (wb_alu_valid && wb_alu_dst != '0 && wb_alu_dst == ex_src2) ?
                     FWD_EXWB : FWD_REG;

endmodule

// File: mul_pipe.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module mul_pipe
   import cpu_pipe_pkg::*;
(
   input  logic                         clk,
   input  logic                         if_id_reset,
   input  logic                         ex_valid,
   input  logic                         ex_is_mul,
   input  reg_idx_t                     ex_dst,
   input  word_t                        ex_opa,
   input  word_t                        ex_opb,
   output logic     [`MUL_STAGES-1:0]   stage_valid,
   output reg_idx_t [`MUL_STAGES-1:0]   stage_dst,
   output logic                         mul_valid,
   output reg_idx_t                     mul_dst,
   output word_t                        mul_result
);

   localparam int LAST  = `MUL_STAGES - 1;
   localparam int CHUNK = `XLEN / LAST;  // Multiplier bits added per stage

   word_t opa_q [LAST-1];
   word_t opb_q [LAST-1];
   word_t acc_q [`MUL_STAGES];

   // One shifted partial product, low word only
   function automatic word_t partial(input word_t a, input word_t b, input int idx);
      word_t digit;
      digit = (b >> (idx * CHUNK)) & ((word_t'(1) << CHUNK) - word_t'(1));
      return (a * digit) << (idx * CHUNK);
   endfunction

   always_ff @(posedge clk) begin
      if (if_id_reset) begin
         stage_valid <= '0;
      end else begin
         stage_valid <= {stage_valid[LAST-1:0], ex_valid & ex_is_mul};
      end
   end

   always_ff @(posedge clk) begin
      stage_dst[0] <= ex_dst;
      opa_q[0]     <= ex_opa;
      opb_q[0]     <= ex_opb;
      acc_q[0]     <= partial(ex_opa, ex_opb, 0);
      for (int k = 1; k < LAST - 1; k++) begin
         opa_q[k] <= opa_q[k-1];
         opb_q[k] <= opb_q[k-1];
      end
      for (int k = 1; k < LAST; k++) begin
         stage_dst[k] <= stage_dst[k-1];
         acc_q[k]     <= acc_q[k-1] + partial(opa_q[k-1], opb_q[k-1], k);
      end
      // Final stage only holds the finished product
      stage_dst[LAST] <= stage_dst[LAST-1];
      acc_q[LAST]     <= acc_q[LAST-1];
   end

   assign mul_valid  = stage_valid[LAST];
   assign mul_dst    = stage_dst[LAST];
   assign mul_result = acc_q[LAST];

endmodule

// File: pipe_cpu.f
+incdir+.
cpu_isa_pkg.sv
cpu_pipe_pkg.sv
fetch_unit.sv
decode_unit.sv
reg_file.sv
alu_exec.sv
mul_pipe.sv
hazard_control.sv
pipe_cpu_top.sv
pipe_cpu_sva.sv
tb_pipe_cpu.sv

// File: pipe_cpu_sva.sv
`timescale 1ns/1ps

module pipe_cpu_sva
   import cpu_pipe_pkg::*;
(
   input logic     clk,
   input logic     if_id_reset,
   input logic     stall,
   input word_t    imem_addr,
   input logic     wb_valid,
   input reg_idx_t wb_reg
);

   int fail_count = 0;

   // Register 0 never retires
   a_wb_reg_nonzero: assert property (@(posedge clk) disable iff (if_id_reset)
      wb_valid |-> wb_reg != '0)
      else begin
         fail_count++;
         $error("writeback strobe for register 0");
      end

   a_pc_hold: assert property (@(posedge clk) disable iff (if_id_reset)
      stall |=> imem_addr == $past(imem_addr))
      else begin
         fail_count++;
         $error("imem_addr moved during a stall");
      end

   // Valids are cleared by the reset edge
   a_wb_quiet_after_reset: assert property (@(posedge clk) if_id_reset |=> !wb_valid)
      else begin
         fail_count++;
         $error("wb_valid high in the cycle after reset");
      end

endmodule

bind pipe_cpu_top pipe_cpu_sva i_sva (
   .clk         (clk),
   .if_id_reset (if_id_reset),
   .stall       (stall),
   .imem_addr   (imem_addr),
   .wb_valid    (wb_valid),
   .wb_reg      (wb_reg)
);

// File: pipe_cpu_top.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module pipe_cpu_top
   import cpu_isa_pkg::*;
   import cpu_pipe_pkg::*;
(
   input  logic     clk,
   input  logic     if_id_reset,
   input  word_t    imem_data,
   output word_t    imem_addr,
   output logic     wb_valid,
   output reg_idx_t wb_reg,
   output word_t    wb_data
);

   logic                       stall;
   word_t                      if_instr;
   reg_idx_t                   src1;
   reg_idx_t                   src2;
   logic                       src2_used;
   reg_idx_t                   id_dst;
   logic                       id_is_alu;
   logic                       id_is_mul;
   word_t                      rd_data1;
   word_t                      rd_data2;
   logic                       ex_valid;
   logic                       ex_is_mul;
   reg_idx_t                   ex_dst;
   alu_op_t                    ex_op;
   word_t                      ex_opa;
   word_t                      ex_opb;
   reg_idx_t                   ex_src1;
   reg_idx_t                   ex_src2;
   fwd_sel_t                   fwd_sel1;
   fwd_sel_t                   fwd_sel2;
   logic                       wb_alu_valid;
   reg_idx_t                   wb_alu_dst;
   word_t                      wb_alu_result;
   logic     [`MUL_STAGES-1:0] stage_valid;
   reg_idx_t [`MUL_STAGES-1:0] stage_dst;
   logic                       mul_valid;
   reg_idx_t                   mul_dst;
   word_t                      mul_result;

   fetch_unit     i_fetch  (.*);
   decode_unit    i_decode (.*);
   alu_exec       i_alu    (.*);
   mul_pipe       i_mul    (.*);
   hazard_control i_hazard (.*);

   reg_file i_reg_file (
      .*,
      .rd_addr1   (src1),
      .rd_addr2   (src2),
      .alu_valid  (wb_alu_valid),
      .alu_dst    (wb_alu_dst),
      .alu_result (wb_alu_result)
   );

endmodule

// File: reg_file.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module reg_file
   import cpu_pipe_pkg::*;
(
   input  logic     clk,
   input  logic     if_id_reset,
   input  reg_idx_t rd_addr1,
   input  reg_idx_t rd_addr2,
   output word_t    rd_data1,
   output word_t    rd_data2,
   input  logic     alu_valid,
   input  reg_idx_t alu_dst,
   input  word_t    alu_result,
   input  logic     mul_valid,
   input  reg_idx_t mul_dst,
   input  word_t    mul_result,
   output logic     wb_valid,
   output reg_idx_t wb_reg,
   output word_t    wb_data
);

   word_t regs [`NUM_REGS];
   logic  wr_any;

   // Hazard control keeps the two retire paths apart
   assign wr_any   = alu_valid | mul_valid;
   assign wb_reg   = alu_valid ? alu_dst : mul_dst;
   assign wb_data  = alu_valid ? alu_result : mul_result;
   assign wb_valid = wr_any && (wb_reg != '0);

   always_ff @(posedge clk) begin
      if (if_id_reset) begin
         for (int i = 0; i < `NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wb_valid) begin
         regs[wb_reg] <= wb_data;
      end
   end

   // Write-through so decode sees a value retiring this cycle
   assign rd_data1 = (rd_addr1 == '0) ? '0 :
                     (wb_valid && wb_reg == rd_addr1) ? wb_data : regs[rd_addr1];
   assign rd_data2 = (rd_addr2 == '0) ? '0 :
                     (wb_valid && wb_reg == rd_addr2) ? wb_data : regs[rd_addr2];

endmodule

// File: tb_pipe_cpu.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module tb_pipe_cpu
   import cpu_isa_pkg::*;
   import cpu_pipe_pkg::*;
();

   localparam int ROM_WORDS   = 1024;
   localparam int DRAIN_LIMIT = 600;
   localparam int ALU_LAT     = 3;  // Fetch to retire without stalls
   localparam int MUL_LAT     = 7;  // Decode, execute, then five multiply stages

   logic     clk;
   logic     if_id_reset;
   word_t    imem_data;
   word_t    imem_addr;
   logic     wb_valid;
   reg_idx_t wb_reg;
   word_t    wb_data;

   word_t    rom [ROM_WORDS];
   word_t    model_regs [`NUM_REGS];
   reg_idx_t pend_reg [$];   // Expected writes in program order
   word_t    pend_data [$];
   int       pend_cyc [$];   // Expected retire cycle or -1 if stalls may move it
   int       prog_len;
   int       errors;
   int       checks;
   int       seed;
   int       cycle;          // Cycles since the reset release

   pipe_cpu_top i_dut (.*);

   // Combinational ROM that returns no-ops past the array
   assign imem_data = (imem_addr < ROM_WORDS * 4) ? rom[imem_addr[11:2]] : '0;

   always #5 clk = ~clk;

   // Cycle 0 presents rom[0]
   always @(posedge clk) begin
      if (if_id_reset) begin
         cycle <= 0;
      end else begin
         cycle <= cycle + 1;
      end
   end

   task automatic check_reg(input reg_idx_t got, input reg_idx_t exp, input string name);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
      end
   endtask

   task automatic check_word(input word_t got, input word_t exp, input string name);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
      end
   endtask

   task automatic check_addr(input word_t got, input word_t exp, input string name);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
      end
   endtask

   function automatic word_t rtype_word(funct_t fn, reg_idx_t rd, reg_idx_t rs, reg_idx_t rt);
      return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
   endfunction

   function automatic word_t addi_word(reg_idx_t rt, reg_idx_t rs, logic [15:0] imm);
      return {OP_ADDI, rs, rt, imm};
   endfunction

   // Reference model that executes in program order and queues each write
   task automatic add_instr(input word_t instr, input int lat);
      logic [5:0] op;
      logic [5:0] fn;
      reg_idx_t   dst;
      word_t      a;
      word_t      b;
      word_t      res;
      logic       known;
      op    = instr[31:26];
      fn    = instr[5:0];
      a     = model_regs[instr[25:21]];
      b     = model_regs[instr[20:16]];
      dst   = instr[15:11];
      res   = '0;
      known = 1'b1;
      if (op == OP_ADDI) begin
         dst = instr[20:16];
         res = a + {{16{instr[15]}}, instr[15:0]};
      end else if (op == OP_RTYPE) begin
         case (fn)
            FN_ADD:  res = a + b;
            FN_SUB:  res = a - b;
            FN_AND:  res = a & b;
            FN_OR:   res = a | b;
            FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            FN_MUL:  res = a * b;  // Low word only
            default: known = 1'b0;
         endcase
      end else begin
         known = 1'b0;
      end
      rom[prog_len] = instr;
      if (known && dst != '0) begin
         model_regs[dst] = res;
         pend_reg.push_back(dst);
         pend_data.push_back(res);
         pend_cyc.push_back((lat > 0) ? prog_len + lat : -1);
      end
      prog_len++;
   endtask

   task automatic match_strobe();
      int hit;
      hit = -1;
      // A timed write must retire in exactly its own cycle
      for (int i = 0; i < pend_cyc.size(); i++) begin
         if (pend_cyc[i] == cycle) hit = i;
      end
      if (hit >= 0) begin
         check_reg(wb_reg, pend_reg[hit], "wb_reg");
      end else begin
         // Walk backwards so the oldest untimed write to this register wins
         for (int i = pend_reg.size() - 1; i >= 0; i--) begin
            if (pend_cyc[i] < 0 && pend_reg[i] == wb_reg) hit = i;
         end
      end
      if (hit < 0) begin
         errors++;
         $display("unexpected writeback to register %0d with data 0x%h", wb_reg, wb_data);
      end else begin
         check_word(wb_data, pend_data[hit], "wb_data");
         pend_reg.delete(hit);
         pend_data.delete(hit);
         pend_cyc.delete(hit);
      end
   endtask

   always @(negedge clk) begin
      if (!if_id_reset && wb_valid !== 1'b0) match_strobe();
   end

   task automatic load_start();
      @(posedge clk);
      #1;
      if_id_reset = 1'b1;
      for (int i = 0; i < ROM_WORDS; i++) rom[i] = '0;
      for (int r = 0; r < `NUM_REGS; r++) model_regs[r] = '0;
      pend_reg.delete();
      pend_data.delete();
      pend_cyc.delete();
      prog_len = 0;
   endtask

   // Two reset cycles before rom[0] is fetched in cycle 0
   task automatic release_reset();
      repeat (2) begin
         @(negedge clk);
         if (wb_valid !== 1'b0) begin
            errors++;
            $display("wb_valid is not low while reset is held");
         end
      end
      check_addr(imem_addr, `RESET_PC, "imem_addr in reset");
      @(posedge clk);
      #1;
      if_id_reset = 1'b0;
   endtask

   task automatic wait_drain(input string what);
      int n;
      n = 0;
      while (pend_reg.size() != 0 && n < DRAIN_LIMIT) begin
         @(posedge clk);
         n++;
      end
      if (pend_reg.size() != 0) begin
         errors++;
         $display("timeout in %s, %0d writebacks never arrived", what, pend_reg.size());
      end
      repeat (12) @(posedge clk);  // Idle tail catches stray strobes
   endtask

   task automatic reset_and_fetch();
      load_start();
      release_reset();
      for (int j = 0; j < 8; j++) begin
         @(negedge clk);
         check_addr(imem_addr, word_t'(j * 4), "imem_addr");
      end
      wait_drain("reset and fetch");
   endtask

   task automatic independent_alu();
      load_start();
      add_instr(addi_word(1, 0, 16'h1234), ALU_LAT);
      add_instr(addi_word(2, 0, 16'hFFF9), ALU_LAT);  // -7
      add_instr(addi_word(3, 0, 16'h8000), ALU_LAT);  // Most negative immediate
      add_instr('0, 0);
      add_instr('0, 0);
      add_instr(rtype_word(FN_SLT, 4, 2, 1), ALU_LAT);
      add_instr(rtype_word(FN_SLT, 5, 1, 2), ALU_LAT);
      add_instr(rtype_word(FN_SUB, 6, 3, 1), ALU_LAT);
      add_instr(rtype_word(FN_AND, 7, 1, 2), ALU_LAT);
      add_instr(rtype_word(FN_OR, 8, 2, 3), ALU_LAT);
      add_instr(rtype_word(FN_SLT, 9, 3, 2), ALU_LAT);
      release_reset();
      wait_drain("independent ALU");
   endtask

   task automatic dependent_chain();
      load_start();
      add_instr(addi_word(1, 0, 16'd10), ALU_LAT);
      add_instr(addi_word(1, 1, 16'hFFFD), ALU_LAT);
      add_instr(rtype_word(FN_ADD, 2, 1, 1), ALU_LAT);
      add_instr(rtype_word(FN_SUB, 3, 2, 1), ALU_LAT);  // r1 through write-through
      add_instr(rtype_word(FN_OR, 1, 3, 2), ALU_LAT);
      add_instr(rtype_word(FN_SLT, 4, 1, 3), ALU_LAT);
      add_instr(rtype_word(FN_AND, 5, 4, 1), ALU_LAT);
      add_instr(addi_word(5, 5, 16'h7FFF), ALU_LAT);
      release_reset();
      wait_drain("dependent chain");
   endtask

   task automatic mul_latency();
      load_start();
      add_instr(addi_word(4, 0, 16'd1234), ALU_LAT);
      add_instr(addi_word(5, 0, 16'hFFC8), ALU_LAT);  // -56
      add_instr('0, 0);
      add_instr(rtype_word(FN_MUL, 6, 4, 5), MUL_LAT);
      release_reset();
      wait_drain("multiply latency");
   endtask

   task automatic mul_dependents();
      load_start();
      add_instr(addi_word(4, 0, 16'h7ABC), 0);
      add_instr(addi_word(5, 0, 16'h1357), 0);
      add_instr('0, 0);
      add_instr(rtype_word(FN_MUL, 6, 4, 5), 0);
      add_instr(rtype_word(FN_ADD, 7, 6, 4), 0);
      add_instr(rtype_word(FN_MUL, 8, 6, 6), 0);
      add_instr(rtype_word(FN_SUB, 9, 8, 7), 0);
      add_instr(addi_word(10, 0, 16'd3), 0);
      add_instr(rtype_word(FN_MUL, 11, 10, 10), 0);  // Operand still in execute
      release_reset();
      wait_drain("multiply dependents");
   endtask

   task automatic mul_waw_mix();
      load_start();
      add_instr(addi_word(1, 0, 16'd5), 0);
      add_instr(addi_word(2, 0, 16'hFFFE), 0);
      add_instr('0, 0);
      add_instr(rtype_word(FN_MUL, 3, 1, 2), 0);
      add_instr(rtype_word(FN_ADD, 3, 1, 2), 0);  // Same destination as the multiply
      add_instr(rtype_word(FN_OR, 4, 1, 2), 0);
      add_instr(rtype_word(FN_SUB, 5, 2, 1), 0);
      add_instr(32'h8C22_0004, 0);  // Load encoding decodes as a no-op
      add_instr(rtype_word(FN_ADD, 6, 3, 0), 0);
      add_instr(rtype_word(FN_MUL, 4, 5, 5), 0);
      add_instr(rtype_word(FN_AND, 7, 1, 2), 0);
      add_instr(rtype_word(FN_ADD, 8, 4, 3), 0);
      release_reset();
      wait_drain("multiply and ALU mix");
   endtask

   task automatic random_program();
      funct_t   fn_list [6] = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT, FN_MUL};
      int       kind;
      reg_idx_t rd;
      reg_idx_t rs;
      reg_idx_t rt;
      load_start();
      for (int i = 0; i < 40; i++) begin
         kind = $unsigned($random(seed)) % 8;
         rd   = reg_idx_t'($unsigned($random(seed)) % 8);  // Few registers give many hazards
         rs   = reg_idx_t'($unsigned($random(seed)) % 8);
         rt   = reg_idx_t'($unsigned($random(seed)) % 8);
         if (kind < 6) begin
            add_instr(rtype_word(fn_list[kind], rd, rs, rt), 0);
         end else if (kind == 6) begin
            add_instr(addi_word(rt, rs, 16'($random(seed))), 0);
         end else begin
            add_instr('0, 0);
         end
      end
      release_reset();
      wait_drain("random program");
   endtask

   initial begin
      clk         = 1'b0;
      if_id_reset = 1'b1;
      errors      = 0;
      checks      = 0;
      seed        = 67;
      prog_len    = 0;
      for (int i = 0; i < ROM_WORDS; i++) rom[i] = '0;
      reset_and_fetch();
      independent_alu();
      dependent_chain();
      mul_latency();
      mul_dependents();
      mul_waw_mix();
      random_program();
      $display("checks %0d, errors %0d, assertion failures %0d",
               checks, errors, i_dut.i_sva.fail_count);
      if (errors == 0 && i_dut.i_sva.fail_count == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule
